// File: src/racing_cfg.svh
`ifndef RACING_CFG_SVH
`define RACING_CFG_SVH

// visible area
`define RG_H_DISPLAY 640
`define RG_V_DISPLAY 480

// horizontal blanking, in pixels
`define RG_H_FRONT 16
`define RG_H_SYNC 96
`define RG_H_BACK 48

// vertical blanking, in lines
`define RG_V_FRONT 10
`define RG_V_SYNC 2
`define RG_V_BACK 33

`define RG_H_TOTAL (`RG_H_DISPLAY + `RG_H_FRONT + `RG_H_SYNC + `RG_H_BACK)
`define RG_V_TOTAL (`RG_V_DISPLAY + `RG_V_FRONT + `RG_V_SYNC + `RG_V_BACK)

// sprites and game start values
`define RG_SPRITE_SIZE 16
`define RG_ENEMY_MARGIN 64
`define RG_PLAYER_Y 180
`define RG_JOY_X0 320
`define RG_JOY_Y0 240
`define RG_ENEMY_X0 320
`define RG_ENEMY_Y0 60
`define RG_START_SPEED 31
`define RG_CRASH_SPEED 16

`endif

// File: src/video_pkg.sv
`default_nettype none

package video_pkg;

	// raster coordinate, wide enough for 800 pixels and 525 lines
	typedef logic [9:0] coord_t;

	// pixel colour, bit order is b, g, r
	typedef enum logic [2:0]
	{
		RGB_BLACK   = 3'b000,
		RGB_RED     = 3'b001,
		RGB_GREEN   = 3'b010,
		RGB_YELLOW  = 3'b011,
		RGB_BLUE    = 3'b100,
		RGB_MAGENTA = 3'b101,
		RGB_CYAN    = 3'b110,
		RGB_WHITE   = 3'b111
	} rgb_t;

endpackage

`default_nettype wire

// File: src/game_pkg.sv
`default_nettype none

package game_pkg;

	// sprite top-left corner on screen
	typedef struct packed
	{
		logic [8:0] x;
		logic [8:0] y;
	} car_pos_t;

	// only the top nibble of speed moves the track
	typedef logic [7:0] speed_t;

	// distance travelled along the track
	typedef logic [15:0] track_pos_t;

	typedef enum logic
	{
		DIR_LEFT  = 1'b0,
		DIR_RIGHT = 1'b1
	} enemy_dir_t;

endpackage

`default_nettype wire

// File: src/video_timing_if.sv
`timescale 1ns/1ps
`default_nettype none

interface video_timing_if;
	import video_pkg::*;

	coord_t hpos;
	coord_t vpos;
	logic   display_on;
	// both syncs are active high
	logic   hsync;
	logic   vsync;
	// one cycle at the first pixel of vertical blanking
	logic   frame_start;

	modport source
	(
		output hpos, vpos, display_on, hsync, vsync, frame_start
	);

	modport sink
	(
		input hpos, vpos, display_on, hsync, vsync, frame_start
	);

endinterface

`default_nettype wire

// File: src/hvsync_generator.sv
`timescale 1ns/1ps
`default_nettype none

`include "racing_cfg.svh"

module hvsync_generator
(
	input  logic           clk100hz,
	input  logic           rst_n,
	video_timing_if.source vt
);
	import video_pkg::*;

	localparam coord_t H_LAST       = coord_t'(`RG_H_TOTAL - 1);
	localparam coord_t V_LAST       = coord_t'(`RG_V_TOTAL - 1);
	localparam coord_t H_SYNC_START = coord_t'(`RG_H_DISPLAY + `RG_H_FRONT);
	localparam coord_t H_SYNC_END   = coord_t'(`RG_H_DISPLAY + `RG_H_FRONT + `RG_H_SYNC);
	localparam coord_t V_SYNC_START = coord_t'(`RG_V_DISPLAY + `RG_V_FRONT);
	localparam coord_t V_SYNC_END   = coord_t'(`RG_V_DISPLAY + `RG_V_FRONT + `RG_V_SYNC);

	coord_t h_next;
	coord_t v_next;

	// next raster position, line wraps first and then the frame
	always_comb
	begin
		h_next = vt.hpos + 10'd1;
		v_next = vt.vpos;
		if (vt.hpos == H_LAST)
		begin
			h_next = '0;
			if (vt.vpos == V_LAST)
				v_next = '0;
			else
				v_next = vt.vpos + 10'd1;
		end
	end

	// syncs are decoded from the next position so they line up with hpos/vpos
	always_ff @(posedge clk100hz or negedge rst_n)
	begin
		if (!rst_n)
		begin
			vt.hpos  <= '0;
			vt.vpos  <= '0;
			vt.hsync <= 1'b0;
			vt.vsync <= 1'b0;
		end
		else
		begin
			vt.hpos  <= h_next;
			vt.vpos  <= v_next;
			vt.hsync <= (h_next >= H_SYNC_START) && (h_next < H_SYNC_END);
			vt.vsync <= (v_next >= V_SYNC_START) && (v_next < V_SYNC_END);
		end
	end

	assign vt.display_on  = (vt.hpos < coord_t'(`RG_H_DISPLAY)) &&
	                        (vt.vpos < coord_t'(`RG_V_DISPLAY));
	assign vt.frame_start = (vt.vpos == coord_t'(`RG_V_DISPLAY)) && (vt.hpos == '0);

	a_raster_in_range: assert property (@(posedge clk100hz) disable iff (!rst_n)
		(vt.hpos <= H_LAST) && (vt.vpos <= V_LAST))
		else $error("raster position outside the frame");

endmodule

`default_nettype wire

// File: src/car_bitmap.sv
`timescale 1ns/1ps
`default_nettype none

module car_bitmap
(
	input  logic [3:0] yofs,
	output logic [7:0] bits
);

	// left half of the car, msb is the outer edge and lsb sits at the centre line
	always_comb
	begin
		case (yofs)
			4'h0: bits = 8'b0000_0000;
			4'h1: bits = 8'b0000_0111;
			4'h2: bits = 8'b0000_1111;
			// front wheels
			4'h3: bits = 8'b1100_1111;
			4'h4: bits = 8'b1101_1111;
			4'h5: bits = 8'b1100_1111;
			// windshield
			4'h6: bits = 8'b0001_1000;
			4'h7: bits = 8'b0001_1000;
			4'h8: bits = 8'b0001_1111;
			4'h9: bits = 8'b0001_1111;
			4'ha: bits = 8'b0001_1111;
			// rear wheels
			4'hb: bits = 8'b1101_1111;
			4'hc: bits = 8'b1101_1111;
			4'hd: bits = 8'b1100_1111;
			4'he: bits = 8'b0011_1111;
			default: bits = 8'b0000_0000;
		endcase
	end

endmodule

`default_nettype wire

// File: src/sprite_renderer.sv
`timescale 1ns/1ps
`default_nettype none

`include "racing_cfg.svh"

module sprite_renderer
(
	input  logic         clk100hz,
	input  logic         rst_n,
	video_timing_if.sink vt,
	input  logic         vstart,
	input  logic         hstart,
	input  logic         load,
	input  logic [7:0]   rom_bits,
	output logic [3:0]   rom_addr,
	output logic         gfx,
	output logic         in_progress
);

	localparam logic [3:0] LAST_ROW = 4'(`RG_SPRITE_SIZE - 1);

	typedef enum logic [2:0]
	{
		S_WAIT_VSTART,
		S_WAIT_LOAD,
		S_FETCH,
		S_WAIT_HSTART,
		S_DRAW_LEFT,
		S_DRAW_RIGHT,
		S_NEXT_ROW
	} state_t;

	state_t     state;
	logic [3:0] ycount;
	logic [2:0] xcount;
	logic [7:0] row_bits;

	// a sprite only starts on a visible line and is cut off at vblank
	always_ff @(posedge clk100hz or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state  <= S_WAIT_VSTART;
			ycount <= '0;
			xcount <= '0;
		end
		else if (vt.frame_start)
			state <= S_WAIT_VSTART;
		else
		begin
			case (state)
				S_WAIT_VSTART:
					if (vstart && vt.display_on)
					begin
						ycount <= '0;
						state  <= S_WAIT_LOAD;
					end
				S_WAIT_LOAD:
					if (load)
						state <= S_FETCH;
				// rom answers in this cycle while load still holds the mux
				S_FETCH:
					state <= S_WAIT_HSTART;
				S_WAIT_HSTART:
					if (hstart)
					begin
						xcount <= '0;
						state  <= S_DRAW_LEFT;
					end
				S_DRAW_LEFT:
				begin
					xcount <= xcount + 3'd1;
					if (xcount == 3'd7)
						state <= S_DRAW_RIGHT;
				end
				S_DRAW_RIGHT:
				begin
					xcount <= xcount + 3'd1;
					if (xcount == 3'd7)
						state <= S_NEXT_ROW;
				end
				S_NEXT_ROW:
				begin
					ycount <= ycount + 4'd1;
					state  <= (ycount == LAST_ROW) ? S_WAIT_VSTART : S_WAIT_LOAD;
				end
				default:
					state <= S_WAIT_VSTART;
			endcase
		end
	end

	always_ff @(posedge clk100hz)
	begin
		if (state == S_FETCH)
			row_bits <= rom_bits;
	end

	assign rom_addr = ycount;

	// left half runs msb first, right half is the mirror image
	always_comb
	begin
		case (state)
			S_DRAW_LEFT:  gfx = row_bits[~xcount];
			S_DRAW_RIGHT: gfx = row_bits[xcount];
			default:      gfx = 1'b0;
		endcase
	end

	assign in_progress = (state != S_WAIT_VSTART);

	a_gfx_visible: assert property (@(posedge clk100hz) disable iff (!rst_n)
		gfx |-> vt.display_on)
		else $error("sprite pixel outside the visible area");

endmodule

`default_nettype wire

// File: src/game_state.sv
`timescale 1ns/1ps
`default_nettype none

`include "racing_cfg.svh"

module game_state
(
	input  logic                 clk100hz,
	input  logic                 rst_n,
	video_timing_if.sink         vt,
	input  logic                 left,
	input  logic                 right,
	input  logic                 up,
	input  logic                 down,
	input  logic                 player_hit,
	output game_pkg::car_pos_t   player,
	output game_pkg::car_pos_t   enemy,
	output game_pkg::track_pos_t track_pos
);
	import video_pkg::*;
	import game_pkg::*;

	localparam coord_t     JOY_X_MAX   = coord_t'(`RG_H_DISPLAY - `RG_SPRITE_SIZE);
	localparam coord_t     JOY_Y_MAX   = coord_t'(`RG_V_DISPLAY - `RG_SPRITE_SIZE);
	localparam logic [8:0] ENEMY_LEFT  = 9'(`RG_ENEMY_MARGIN);
	localparam coord_t     ENEMY_RIGHT = coord_t'(`RG_H_DISPLAY - `RG_ENEMY_MARGIN);

	coord_t     joy_x;
	coord_t     joy_y;
	coord_t     joy_x_next;
	coord_t     joy_y_next;
	speed_t     speed;
	speed_t     speed_target;
	enemy_dir_t enemy_dir;
	enemy_dir_t enemy_dir_next;
	logic       enemy_hit_edge;
	logic       collision;
	logic [3:0] step;

	// one joystick step per frame, left has the highest priority
	always_comb
	begin
		joy_x_next = joy_x;
		joy_y_next = joy_y;
		if (left && (joy_x != '0))
			joy_x_next = joy_x - 10'd1;
		else if (right && (joy_x != JOY_X_MAX))
			joy_x_next = joy_x + 10'd1;
		else if (up && (joy_y != '0))
			joy_y_next = joy_y - 10'd1;
		else if (down && (joy_y != JOY_Y_MAX))
			joy_y_next = joy_y + 10'd1;
	end

	assign step           = speed[7:4];
	assign speed_target   = ~joy_y_next[7:0];
	assign enemy_hit_edge = (enemy.x == ENEMY_LEFT) || ({1'b0, enemy.x} == ENEMY_RIGHT);
	assign enemy_dir_next = enemy_hit_edge ?
	                        ((enemy_dir == DIR_RIGHT) ? DIR_LEFT : DIR_RIGHT) : enemy_dir;

	always_ff @(posedge clk100hz or negedge rst_n)
	begin
		if (!rst_n)
		begin
			joy_x     <= coord_t'(`RG_JOY_X0);
			joy_y     <= coord_t'(`RG_JOY_Y0);
			player    <= '{x: 9'(`RG_JOY_X0), y: 9'(`RG_PLAYER_Y)};
			enemy     <= '{x: 9'(`RG_ENEMY_X0), y: 9'(`RG_ENEMY_Y0)};
			enemy_dir <= DIR_LEFT;
			speed     <= speed_t'(`RG_START_SPEED);
			track_pos <= '0;
		end
		else if (vt.frame_start)
		begin
			joy_x     <= joy_x_next;
			joy_y     <= joy_y_next;
			player.x  <= joy_x_next[8:0];
			player.y  <= 9'(`RG_PLAYER_Y);
			enemy_dir <= enemy_dir_next;
			enemy.x   <= (enemy_dir_next == DIR_RIGHT) ? enemy.x + 9'd1 : enemy.x - 9'd1;
			enemy.y   <= enemy.y + {5'd0, step};
			track_pos <= track_pos + {12'd0, step};
			// a crash costs speed, otherwise speed creeps towards the stick
			if (collision)
				speed <= speed_t'(`RG_CRASH_SPEED);
			else if (speed < speed_target)
				speed <= speed + 8'd1;
			else if (speed != '0)
				speed <= speed - 8'd1;
		end
	end

	// collision is held from the first hit until the next frame update
	always_ff @(posedge clk100hz or negedge rst_n)
	begin
		if (!rst_n)
			collision <= 1'b0;
		else if (vt.frame_start)
			collision <= 1'b0;
		else if (player_hit)
			collision <= 1'b1;
	end

	a_joy_x_clamped: assert property (@(posedge clk100hz) disable iff (!rst_n)
		joy_x <= JOY_X_MAX)
		else $error("joystick x beyond the right screen edge");

endmodule

`default_nettype wire

// File: src/pixel_compositor.sv
`timescale 1ns/1ps
`default_nettype none

`include "racing_cfg.svh"

module pixel_compositor
(
	input  logic                 clk100hz,
	input  logic                 rst_n,
	video_timing_if.sink         vt,
	input  game_pkg::car_pos_t   player,
	input  game_pkg::car_pos_t   enemy,
	input  game_pkg::track_pos_t track_pos,
	input  logic [3:0]           player_rom_addr,
	input  logic [3:0]           enemy_rom_addr,
	input  logic                 player_gfx,
	input  logic                 enemy_gfx,
	output logic [3:0]           car_rom_addr,
	output logic                 player_load,
	output logic                 enemy_load,
	output logic                 player_vstart,
	output logic                 player_hstart,
	output logic                 enemy_vstart,
	output logic                 enemy_hstart,
	output logic                 player_hit,
	output video_pkg::rgb_t      rgb
);
	import video_pkg::*;

	localparam coord_t PLAYER_LOAD_START = coord_t'(`RG_H_DISPLAY);
	localparam coord_t ENEMY_LOAD_START  = coord_t'(`RG_H_DISPLAY + 4);

	logic track_offside;
	logic track_shoulder;
	logic track_gfx;
	logic red;
	logic green;
	logic blue;

	// hblank is split between the two renderers for the shared rom
	assign player_load  = (vt.hpos >= PLAYER_LOAD_START) && (vt.hpos < ENEMY_LOAD_START);
	assign enemy_load   = (vt.hpos >= ENEMY_LOAD_START);
	assign car_rom_addr = player_load ? player_rom_addr : enemy_rom_addr;

	assign player_vstart = ({1'b0, player.y} == vt.vpos);
	assign player_hstart = ({1'b0, player.x} == vt.hpos);
	assign enemy_vstart  = ({1'b0, enemy.y} == vt.vpos);
	assign enemy_hstart  = ({1'b0, enemy.x} == vt.hpos);

	// grass at both sides with dashes that scroll with the track
	assign track_offside  = (vt.hpos[7:5] == 3'd0) || (vt.hpos[7:5] == 3'd7);
	assign track_shoulder = (vt.hpos[7:3] == 5'd3) || (vt.hpos[7:3] == 5'd28);
	assign track_gfx      = (vt.vpos[5:1] != track_pos[5:1]) && track_offside;

	assign player_hit = player_gfx && (enemy_gfx || track_gfx);

	assign red   = vt.display_on && (player_gfx || enemy_gfx || track_shoulder);
	assign green = vt.display_on && (player_gfx || track_gfx);
	assign blue  = vt.display_on && (enemy_gfx || track_shoulder);

	always_ff @(posedge clk100hz or negedge rst_n)
	begin
		if (!rst_n)
			rgb <= RGB_BLACK;
		else
			rgb <= rgb_t'({blue, green, red});
	end

endmodule

`default_nettype wire

// File: src/racing_game_top.sv
`timescale 1ns/1ps
`default_nettype none

module racing_game_top
(
	input  logic       clk100hz,
	input  logic       rst_n,
	input  logic       left,
	input  logic       right,
	input  logic       up,
	input  logic       down,
	output logic       hsync,
	output logic       vsync,
	output logic [2:0] rgb
);
	import game_pkg::*;

	car_pos_t   player;
	car_pos_t   enemy;
	track_pos_t track_pos;
	logic [3:0] player_rom_addr;
	logic [3:0] enemy_rom_addr;
	logic [3:0] car_rom_addr;
	logic [7:0] car_rom_bits;
	logic       player_load;
	logic       enemy_load;
	logic       player_vstart;
	logic       player_hstart;
	logic       enemy_vstart;
	logic       enemy_hstart;
	logic       player_gfx;
	logic       enemy_gfx;
	logic       player_hit;

	video_timing_if vt ();

	hvsync_generator u_hvsync_generator
	(
		.clk100hz (clk100hz),
		.rst_n    (rst_n),
		.vt       (vt)
	);

	car_bitmap u_car_bitmap
	(
		.yofs (car_rom_addr),
		.bits (car_rom_bits)
	);

	sprite_renderer u_player_renderer
	(
		.clk100hz    (clk100hz),
		.rst_n       (rst_n),
		.vt          (vt),
		.vstart      (player_vstart),
		.hstart      (player_hstart),
		.load        (player_load),
		.rom_bits    (car_rom_bits),
		.rom_addr    (player_rom_addr),
		.gfx         (player_gfx),
		.in_progress ()
	);

	sprite_renderer u_enemy_renderer
	(
		.clk100hz    (clk100hz),
		.rst_n       (rst_n),
		.vt          (vt),
		.vstart      (enemy_vstart),
		.hstart      (enemy_hstart),
		.load        (enemy_load),
		.rom_bits    (car_rom_bits),
		.rom_addr    (enemy_rom_addr),
		.gfx         (enemy_gfx),
		.in_progress ()
	);

	game_state u_game_state
	(
		.clk100hz   (clk100hz),
		.rst_n      (rst_n),
		.vt         (vt),
		.left       (left),
		.right      (right),
		.up         (up),
		.down       (down),
		.player_hit (player_hit),
		.player     (player),
		.enemy      (enemy),
		.track_pos  (track_pos)
	);

	pixel_compositor u_pixel_compositor
	(
		.clk100hz        (clk100hz),
		.rst_n           (rst_n),
		.vt              (vt),
		.player          (player),
		.enemy           (enemy),
		.track_pos       (track_pos),
		.player_rom_addr (player_rom_addr),
		.enemy_rom_addr  (enemy_rom_addr),
		.player_gfx      (player_gfx),
		.enemy_gfx       (enemy_gfx),
		.car_rom_addr    (car_rom_addr),
		.player_load     (player_load),
		.enemy_load      (enemy_load),
		.player_vstart   (player_vstart),
		.player_hstart   (player_hstart),
		.enemy_vstart    (enemy_vstart),
		.enemy_hstart    (enemy_hstart),
		.player_hit      (player_hit),
		.rgb             (rgb)
	);

	// rgb is one cycle late, so delay the syncs to match
	always_ff @(posedge clk100hz or negedge rst_n)
	begin
		if (!rst_n)
		begin
			hsync <= 1'b0;
			vsync <= 1'b0;
		end
		else
		begin
			hsync <= vt.hsync;
			vsync <= vt.vsync;
		end
	end

endmodule

`default_nettype wire

// File: sim/racing_game_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "racing_cfg.svh"

module racing_game_checker
(
	input  logic       clk100hz,
	input  logic       rst_n,
	input  logic       left,
	input  logic       right,
	input  logic       up,
	input  logic       down,
	input  logic       hsync,
	input  logic       vsync,
	input  logic [2:0] rgb,
	output int         checks,
	output int         errors,
	output int         player_pixels,
	output int         enemy_pixels
);

	localparam int H_DISPLAY    = `RG_H_DISPLAY;
	localparam int V_DISPLAY    = `RG_V_DISPLAY;
	localparam int H_TOTAL      = `RG_H_TOTAL;
	localparam int V_TOTAL      = `RG_V_TOTAL;
	localparam int H_SYNC_START = `RG_H_DISPLAY + `RG_H_FRONT;
	localparam int H_SYNC_END   = `RG_H_DISPLAY + `RG_H_FRONT + `RG_H_SYNC;
	localparam int V_SYNC_START = `RG_V_DISPLAY + `RG_V_FRONT;
	localparam int V_SYNC_END   = `RG_V_DISPLAY + `RG_V_FRONT + `RG_V_SYNC;
	localparam int JOY_X_MAX    = `RG_H_DISPLAY - `RG_SPRITE_SIZE;
	localparam int JOY_Y_MAX    = `RG_V_DISPLAY - `RG_SPRITE_SIZE;
	localparam int SIZE         = `RG_SPRITE_SIZE;

	// reference raster and game state
	int         m_h;
	int         m_v;
	int         joy_x;
	int         joy_y;
	int         player_x;
	int         player_y;
	int         enemy_x;
	int         enemy_y;
	int         speed;
	int         track;
	bit         enemy_right;
	bit         crashed;
	bit         model_valid;

	// outputs expected after the coming rising edge
	logic       exp_hsync;
	logic       exp_vsync;
	logic [2:0] exp_rgb;
	int         exp_h;
	int         exp_v;

	// left half of the car shape, msb at the outer edge
	function automatic logic [7:0] car_shape_row(input logic [3:0] row);
		case (row)
			4'h1: return 8'b0000_0111;
			4'h2: return 8'b0000_1111;
			4'h3: return 8'b1100_1111;
			4'h4: return 8'b1101_1111;
			4'h5: return 8'b1100_1111;
			4'h6: return 8'b0001_1000;
			4'h7: return 8'b0001_1000;
			4'h8: return 8'b0001_1111;
			4'h9: return 8'b0001_1111;
			4'ha: return 8'b0001_1111;
			4'hb: return 8'b1101_1111;
			4'hc: return 8'b1101_1111;
			4'hd: return 8'b1100_1111;
			4'he: return 8'b0011_1111;
			default: return 8'b0000_0000;
		endcase
	endfunction

	// row r is fetched in the hblank of line y+r and shows one pixel right of x
	function automatic bit sprite_pixel(input int x, input int y, input int h, input int v);
		int         row;
		int         col;
		logic [7:0] shape;
		if ((y >= V_DISPLAY) || (v >= V_DISPLAY))
			return 1'b0;
		row = v - y - 1;
		col = h - x - 1;
		if ((row < 0) || (row >= SIZE) || (col < 0) || (col >= SIZE))
			return 1'b0;
		shape = car_shape_row(4'(row));
		return (col < 8) ? shape[7 - col] : shape[col - 8];
	endfunction

	task automatic reset_model();
		m_h         = 0;
		m_v         = 0;
		joy_x       = `RG_JOY_X0;
		joy_y       = `RG_JOY_Y0;
		player_x    = `RG_JOY_X0;
		player_y    = `RG_PLAYER_Y;
		enemy_x     = `RG_ENEMY_X0;
		enemy_y     = `RG_ENEMY_Y0;
		enemy_right = 1'b0;
		speed       = `RG_START_SPEED;
		track       = 0;
		crashed     = 1'b0;
		exp_hsync   = 1'b0;
		exp_vsync   = 1'b0;
		exp_rgb     = 3'b000;
		model_valid = 1'b0;
	endtask

	// once per frame, at the first pixel of vertical blanking
	task automatic update_game();
		int step;
		step = speed / 16;
		if (left && (joy_x > 0))
			joy_x--;
		else if (right && (joy_x < JOY_X_MAX))
			joy_x++;
		else if (up && (joy_y > 0))
			joy_y--;
		else if (down && (joy_y < JOY_Y_MAX))
			joy_y++;
		player_x = joy_x;
		player_y = `RG_PLAYER_Y;
		if ((enemy_x == `RG_ENEMY_MARGIN) || (enemy_x == H_DISPLAY - `RG_ENEMY_MARGIN))
			enemy_right = !enemy_right;
		enemy_x = enemy_right ? enemy_x + 1 : enemy_x - 1;
		enemy_y = (enemy_y + step) % 512;
		track   = (track + step) % 65536;
		if (crashed)
			speed = `RG_CRASH_SPEED;
		else if (speed < 255 - (joy_y % 256))
			speed++;
		else if (speed > 0)
			speed--;
	endtask

	always @(posedge clk100hz)
	begin : model_step
		logic disp;
		logic pg;
		logic eg;
		logic tg;
		logic sh;
		if (!rst_n)
			reset_model();
		else
		begin
			disp = (m_h < H_DISPLAY) && (m_v < V_DISPLAY);
			pg   = sprite_pixel(player_x, player_y, m_h, m_v);
			eg   = sprite_pixel(enemy_x, enemy_y, m_h, m_v);
			tg   = ((((m_h / 32) % 8) == 0) || (((m_h / 32) % 8) == 7)) &&
			       (((m_v / 2) % 32) != ((track / 2) % 32));
			sh   = (((m_h / 8) % 32) == 3) || (((m_h / 8) % 32) == 28);
			exp_rgb   = disp ? {eg | sh, pg | tg, pg | eg | sh} : 3'b000;
			exp_hsync = (m_h >= H_SYNC_START) && (m_h < H_SYNC_END);
			exp_vsync = (m_v >= V_SYNC_START) && (m_v < V_SYNC_END);
			exp_h     = m_h;
			exp_v     = m_v;
			if (disp && pg)
				player_pixels++;
			if (disp && eg)
				enemy_pixels++;
			if ((m_v == V_DISPLAY) && (m_h == 0))
			begin
				update_game();
				crashed = 1'b0;
			end
			else if (pg && (eg || tg))
				crashed = 1'b1;
			m_h++;
			if (m_h == H_TOTAL)
			begin
				m_h = 0;
				m_v = (m_v + 1) % V_TOTAL;
			end
			model_valid = 1'b1;
		end
	end

	task automatic report_mismatch(input string what, input logic [2:0] got,
	                               input logic [2:0] want);
		errors++;
		$display("CHECK FAILED at %0t: %s for hpos %0d vpos %0d is %b, expected %b",
		         $time, what, exp_h, exp_v, got, want);
	endtask

	// outputs settle well before the falling edge
	always @(negedge clk100hz)
	begin
		if (model_valid)
		begin
			checks++;
			if (hsync !== exp_hsync)
				report_mismatch("hsync", {2'b00, hsync}, {2'b00, exp_hsync});
			if (vsync !== exp_vsync)
				report_mismatch("vsync", {2'b00, vsync}, {2'b00, exp_vsync});
			if (rgb !== exp_rgb)
				report_mismatch("rgb", rgb, exp_rgb);
		end
	end

endmodule

`default_nettype wire

// File: sim/racing_game_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "racing_cfg.svh"

module racing_game_tb;

	localparam int     CLK_PERIOD   = 100;
	localparam int     RESET_CYCLES = 3;
	localparam int     FRAME_CYCLES = `RG_H_TOTAL * `RG_V_TOTAL;
	localparam int     TEST_FRAMES  = 5;
	localparam longint WATCHDOG_NS  =
		longint'(RESET_CYCLES + (TEST_FRAMES + 1) * FRAME_CYCLES) * CLK_PERIOD;

	logic        clk100hz;
	logic        rst_n;
	logic        left;
	logic        right;
	logic        up;
	logic        down;
	logic        hsync;
	logic        vsync;
	logic [2:0]  rgb;
	logic [15:0] lfsr;
	int          checks;
	int          errors;
	int          player_pixels;
	int          enemy_pixels;
	int          failures;

	racing_game_top u_racing_game_top
	(
		.clk100hz (clk100hz),
		.rst_n    (rst_n),
		.left     (left),
		.right    (right),
		.up       (up),
		.down     (down),
		.hsync    (hsync),
		.vsync    (vsync),
		.rgb      (rgb)
	);

	racing_game_checker u_racing_game_checker
	(
		.clk100hz      (clk100hz),
		.rst_n         (rst_n),
		.left          (left),
		.right         (right),
		.up            (up),
		.down          (down),
		.hsync         (hsync),
		.vsync         (vsync),
		.rgb           (rgb),
		.checks        (checks),
		.errors        (errors),
		.player_pixels (player_pixels),
		.enemy_pixels  (enemy_pixels)
	);

	// x^16 + x^14 + x^13 + x^11 + 1, shifting right
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
	endfunction

	// one lfsr step for each joystick bit
	task automatic draw_joystick();
		logic [3:0] bits;
		for (int i = 0; i < 4; i++)
		begin
			lfsr    = lfsr_next(lfsr);
			bits[i] = lfsr[0];
		end
		{down, up, right, left} = bits;
	endtask

	initial
	begin
		clk100hz = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk100hz = ~clk100hz;
	end

	initial
	begin
		rst_n    = 1'b0;
		left     = 1'b0;
		right    = 1'b0;
		up       = 1'b0;
		down     = 1'b0;
		lfsr     = 16'd21711;
		failures = 0;
		repeat (RESET_CYCLES) @(negedge clk100hz);
		rst_n = 1'b1;
		draw_joystick();
		// new stick position each frame, well away from the frame_start sample
		for (int f = 0; f < TEST_FRAMES; f++)
		begin
			@(posedge vsync);
			@(negedge clk100hz);
			draw_joystick();
		end
		@(negedge clk100hz);
		#(CLK_PERIOD / 4);
		if (player_pixels == 0)
		begin
			$display("the player car never appeared on screen");
			failures++;
		end
		if (enemy_pixels == 0)
		begin
			$display("the enemy car never appeared on screen");
			failures++;
		end
		$display("checks %0d, mismatches %0d, other failures %0d", checks, errors, failures);
		if ((errors == 0) && (failures == 0))
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS + CLK_PERIOD / 4);
		$display("timeout: %0d frames did not complete in time", TEST_FRAMES);
		$display("checks %0d, mismatches %0d, other failures %0d", checks, errors, failures);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// File: racing_game_top.f
+incdir+src
src/video_pkg.sv
src/game_pkg.sv
src/video_timing_if.sv
src/hvsync_generator.sv
src/car_bitmap.sv
src/sprite_renderer.sv
src/game_state.sv
src/pixel_compositor.sv
src/racing_game_top.sv
sim/racing_game_checker.sv
sim/racing_game_tb.sv
